//--- logic/astro_pkg.sv
package astro_pkg;

	// ======================================================================
	// Widths with a meaning
	// ======================================================================

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  game_id_t;
	typedef logic [8:0]  player_buttons_t;
	typedef logic [3:0]  color_t;
	typedef logic [8:0]  hcount_t;
	typedef logic [10:0] vcount_t;
	typedef logic [7:0]  chip_audio_t;
	typedef logic [15:0] sample_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	// Button positions inside player_buttons_t, all active high
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_FIRE   = 4;
	localparam int BTN_FIRE2  = 5;
	localparam int BTN_START1 = 6;
	localparam int BTN_START2 = 7;
	localparam int BTN_COIN   = 8;

	// ======================================================================
	// Download bus and game selection
	// ======================================================================

	// Host download indexes
	localparam dl_index_t IDX_GAME = 8'd1;
	localparam dl_index_t IDX_DIP  = 8'd254;

	// Game numbers as sent by the host
	localparam game_id_t GAME_EBASE    = 8'd1;
	localparam game_id_t GAME_SEAWOLF2 = 8'd2;
	localparam game_id_t GAME_SPACEZAP = 8'd3;
	localparam game_id_t GAME_GORF     = 8'd4;
	localparam game_id_t GAME_WOW      = 8'd5;
	localparam game_id_t GAME_ROBBY    = 8'd6;
	localparam game_id_t GAME_GORF1    = 8'd7;

	// DIP switch banks and the address bits that select one
	localparam int DIP_BANKS  = 8;
	localparam int DIP_SEL_W  = $clog2(DIP_BANKS);

	// Idle switch row, nothing pressed
	localparam byte_t ROW_IDLE = 8'hff;

	// ======================================================================
	// Video
	// ======================================================================

	// Second interlace field starts after this line
	localparam vcount_t VLINES_FIELD = 11'd263;

	// Visible window edges, blanked at or beyond these
	localparam vcount_t VTOP_LAST  = 11'd21;
	localparam vcount_t VBOT_FIRST = 11'd260;
	localparam hcount_t HLEFT_LAST = 9'd70;

	// Grey levels for Space Zap mono
	localparam color_t MONO_BRIGHT = 4'd14;
	localparam color_t MONO_MID    = 4'd10;
	localparam color_t MONO_DIM    = 4'd8;

endpackage

//--- logic/game_config.sv
`timescale 1ns/1ps

module game_config (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                dl_wr,
	input  astro_pkg::dl_index_t dl_index,
	input  astro_pkg::dl_addr_t  dl_addr,
	input  astro_pkg::byte_t     dl_data,
	output logic                is_ebase,
	output logic                is_spacezap,
	output logic                is_gorf,
	output logic                is_wow,
	output logic                is_robby,
	output logic                gorf_prog1,
	output astro_pkg::byte_t     dip0,
	output astro_pkg::byte_t     dip2,
	output astro_pkg::byte_t     dip3
);

	import astro_pkg::*;

	game_id_t game_id;
	byte_t    dip_bank [DIP_BANKS];

	// Write decodes
	logic game_wr;
	logic dip_wr;

	assign game_wr = dl_wr && (dl_index == IDX_GAME);
	// Only the first eight addresses hit a bank
	assign dip_wr  = dl_wr && (dl_index == IDX_DIP) && (dl_addr[$bits(dl_addr_t)-1:DIP_SEL_W] == '0);

	// ======================================================================
	// Game id and DIP registers
	// ======================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_id <= '0;
			for (int i = 0; i < DIP_BANKS; i++) begin
				dip_bank[i] <= '0;
			end
		end else begin
			if (game_wr) begin
				game_id <= dl_data;
			end
			if (dip_wr) begin
				dip_bank[dl_addr[DIP_SEL_W-1:0]] <= dl_data;
			end
		end
	end

	// Flag decode, one edge behind the id
	// Seawolf II and unknown ids fall through with every flag low
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			is_ebase    <= 1'b0;
			is_spacezap <= 1'b0;
			is_gorf     <= 1'b0;
			is_wow      <= 1'b0;
			is_robby    <= 1'b0;
			gorf_prog1  <= 1'b0;
		end else begin
			is_ebase    <= (game_id == GAME_EBASE);
			is_spacezap <= (game_id == GAME_SPACEZAP);
			// Program 1 is still Gorf hardware
			is_gorf     <= (game_id == GAME_GORF) || (game_id == GAME_GORF1);
			is_wow      <= (game_id == GAME_WOW);
			is_robby    <= (game_id == GAME_ROBBY);
			gorf_prog1  <= (game_id == GAME_GORF1);
		end
	end

	// Banks read by the kept games
	assign dip0 = dip_bank[0];
	assign dip2 = dip_bank[2];
	assign dip3 = dip_bank[3];

endmodule

//--- logic/switch_matrix.sv
`timescale 1ns/1ps

module switch_matrix (
	input  astro_pkg::byte_t           col_select,
	input  astro_pkg::player_buttons_t p1,
	input  astro_pkg::player_buttons_t p2,
	input  logic                      speech_busy,
	input  logic                      is_ebase,
	input  logic                      is_spacezap,
	input  logic                      is_gorf,
	input  logic                      is_wow,
	input  logic                      is_robby,
	input  astro_pkg::byte_t           dip0,
	input  astro_pkg::byte_t           dip2,
	input  astro_pkg::byte_t           dip3,
	output astro_pkg::byte_t           row_data
);

	import astro_pkg::*;

	// Switches read low when pressed
	// Starts and coin all come from the player 1 controller
	logic s1_n, s2_n, coin_n;
	logic f1_n, r1_n, l1_n, d1_n, u1_n, fb1;
	logic f2_n, r2_n, l2_n, d2_n, u2_n, fb2;

	assign s1_n   = ~p1[BTN_START1];
	assign s2_n   = ~p1[BTN_START2];
	assign coin_n = ~p1[BTN_COIN];

	assign f1_n = ~p1[BTN_FIRE];
	assign r1_n = ~p1[BTN_RIGHT];
	assign l1_n = ~p1[BTN_LEFT];
	assign d1_n = ~p1[BTN_DOWN];
	assign u1_n = ~p1[BTN_UP];
	// Wizard of Wor move button reads active high
	assign fb1  = p1[BTN_FIRE2];

	assign f2_n = ~p2[BTN_FIRE];
	assign r2_n = ~p2[BTN_RIGHT];
	assign l2_n = ~p2[BTN_LEFT];
	assign d2_n = ~p2[BTN_DOWN];
	assign u2_n = ~p2[BTN_UP];
	assign fb2  = p2[BTN_FIRE2];

	// ======================================================================
	// Per-game row layouts listed from bit 7 down
	// ======================================================================

	// Extra Bases with digital buttons only
	byte_t col1_eb, col2_eb;
	assign col1_eb = {2'b11, s2_n, s1_n, 2'b11, f1_n, f2_n};
	assign col2_eb = {1'b1, dip0[0], 1'b1, dip0[1], 3'b111, coin_n};

	// Space Zap
	byte_t col1_sz, col2_sz, col4_sz;
	assign col1_sz = {2'b11, s2_n, s1_n, dip2[1], 1'b1, coin_n, 1'b1};
	assign col2_sz = {3'b111, f2_n, r2_n, l2_n, d2_n, u2_n};
	assign col4_sz = {2'b11, dip2[0], f1_n, r1_n, l1_n, d1_n, u1_n};

	// Wizard of Wor on the digital stick
	byte_t col1_ww, col2_ww, col4_ww;
	assign col1_ww = {dip2[2], s2_n, s1_n, 1'b1, dip2[1], 1'b1, coin_n, 1'b1};
	assign col2_ww = {2'b11, f2_n, fb2, r2_n, l2_n, d2_n, u2_n};
	assign col4_ww = {speech_busy, 1'b1, f1_n, fb1, r1_n, l1_n, d1_n, u1_n};

	// Gorf and Gorf program 1 share a layout
	byte_t col1_gf, col2_gf, col4_gf;
	assign col1_gf = {dip2[2], dip2[0], s2_n, s1_n, 1'b1, dip2[1], coin_n, 1'b1};
	assign col2_gf = {3'b001, f2_n, r2_n, l2_n, d2_n, u2_n};
	assign col4_gf = {speech_busy, 2'b01, f1_n, r1_n, l1_n, d1_n, u1_n};

	// Robby Roto
	// Player 1 stick is wired in reverse order
	byte_t col1_rr, col2_rr, col4_rr;
	assign col1_rr = {1'b0, s2_n, s1_n, 1'b1, dip2[1], 1'b1, coin_n, 1'b1};
	assign col2_rr = {2'b11, f2_n, 1'b1, r2_n, l2_n, d2_n, u2_n};
	assign col4_rr = {2'b11, f1_n, 1'b1, u1_n, d1_n, l1_n, r1_n};

	// Column 8 is DIP bank 3 for every kept game but Extra Bases
	logic col8_dip;
	assign col8_dip = is_spacezap | is_gorf | is_wow | is_robby;

	// ======================================================================
	// Column decode in the same cycle as the scan
	// ======================================================================

	always_comb begin
		row_data = ROW_IDLE;
		case (col_select)
			8'h01: begin
				if (is_ebase)         row_data = col1_eb;
				else if (is_spacezap) row_data = col1_sz;
				else if (is_gorf)     row_data = col1_gf;
				else if (is_wow)      row_data = col1_ww;
				else if (is_robby)    row_data = col1_rr;
			end
			8'h02: begin
				if (is_ebase)         row_data = col2_eb;
				else if (is_spacezap) row_data = col2_sz;
				else if (is_gorf)     row_data = col2_gf;
				else if (is_wow)      row_data = col2_ww;
				else if (is_robby)    row_data = col2_rr;
			end
			8'h04: begin
				// Extra Bases reads its DIPs straight off this column
				if (is_ebase)         row_data = dip2;
				else if (is_spacezap) row_data = col4_sz;
				else if (is_gorf)     row_data = col4_gf;
				else if (is_wow)      row_data = col4_ww;
				else if (is_robby)    row_data = col4_rr;
			end
			8'h08: begin
				if (col8_dip)         row_data = dip3;
			end
			default: row_data = ROW_IDLE;
		endcase
	end

endmodule

//--- logic/video_post.sv
`timescale 1ns/1ps

module video_post (
	input  logic               clk_sys,
	input  logic               reset,
	input  astro_pkg::color_t  r_in,
	input  astro_pkg::color_t  g_in,
	input  astro_pkg::color_t  b_in,
	input  astro_pkg::hcount_t hcount,
	input  astro_pkg::vcount_t vcount,
	input  logic               is_spacezap,
	input  logic               mono_mode,
	output astro_pkg::color_t  r_out,
	output astro_pkg::color_t  g_out,
	output astro_pkg::color_t  b_out
);

	import astro_pkg::*;

	// Second field lines map back onto the first
	vcount_t vfold;
	assign vfold = (vcount > VLINES_FIELD) ? vcount - VLINES_FIELD : vcount;

	// Edge region goes black
	logic edge_blank;
	assign edge_blank = (vfold >= VBOT_FIRST) || (vfold <= VTOP_LAST) || (hcount <= HLEFT_LAST);

	// ======================================================================
	// Next pixel
	// ======================================================================

	color_t r_nxt, g_nxt, b_nxt;
	color_t grey;
	logic   grey_hit;

	always_comb begin
		// Mono recolour, checks in order so the last match wins
		grey     = MONO_BRIGHT;
		grey_hit = 1'b0;
		if ((g_in == 4'd15) && (b_in == 4'd4)) begin
			grey     = MONO_BRIGHT;
			grey_hit = 1'b1;
		end
		if (b_in == 4'd11) begin
			grey     = MONO_MID;
			grey_hit = 1'b1;
		end
		if (g_in == 4'd4) begin
			grey     = MONO_DIM;
			grey_hit = 1'b1;
		end

		if (edge_blank) begin
			r_nxt = '0;
			g_nxt = '0;
			b_nxt = '0;
		end else if (is_spacezap && mono_mode && grey_hit) begin
			r_nxt = grey;
			g_nxt = grey;
			b_nxt = grey;
		end else begin
			r_nxt = r_in;
			g_nxt = g_in;
			b_nxt = b_in;
		end
	end

	// One pixel of latency, black out of reset
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			r_out <= '0;
			g_out <= '0;
			b_out <= '0;
		end else begin
			r_out <= r_nxt;
			g_out <= g_nxt;
			b_out <= b_nxt;
		end
	end

endmodule

//--- logic/audio_mix.sv
`timescale 1ns/1ps

module audio_mix (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  astro_pkg::chip_audio_t chip_l,
	input  astro_pkg::chip_audio_t chip_r,
	input  astro_pkg::sample_t     samp_l,
	input  astro_pkg::sample_t     samp_r,
	input  logic                   is_gorf,
	input  logic                   is_wow,
	input  logic                   is_robby,
	output astro_pkg::sample_t     audio_l,
	output astro_pkg::sample_t     audio_r
);

	import astro_pkg::*;

	// Votrax games add a quarter of the speech sample to the chip
	function automatic sample_t mix(input chip_audio_t chip, input sample_t samp, input logic plus);
		sample_t chip_wide;
		chip_wide = {2'b00, chip, chip[7:2]};
		if (plus) begin
			return chip_wide + {2'b00, samp[15:2]};
		end
		return {chip, chip};
	endfunction

	logic plus_samples;
	logic stereo;

	assign plus_samples = is_gorf | is_wow;
	// Two sound chips fitted
	assign stereo       = is_gorf | is_wow | is_robby;

	chip_audio_t chip_right;
	assign chip_right = stereo ? chip_r : chip_l;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix(chip_l, samp_l, plus_samples);
			audio_r <= mix(chip_right, samp_r, plus_samples);
		end
	end

endmodule

//--- logic/astro_io_top.sv
`timescale 1ns/1ps

module astro_io_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Host download
	input  logic                      dl_wr,
	input  astro_pkg::dl_index_t       dl_index,
	input  astro_pkg::dl_addr_t        dl_addr,
	input  astro_pkg::byte_t           dl_data,
	// Switch matrix scan from the CPU
	input  astro_pkg::byte_t           col_select,
	input  astro_pkg::player_buttons_t p1,
	input  astro_pkg::player_buttons_t p2,
	input  logic                      speech_busy,
	output astro_pkg::byte_t           row_data,
	output logic                      gorf_prog1,
	// Pixel stream
	input  astro_pkg::color_t          r_in,
	input  astro_pkg::color_t          g_in,
	input  astro_pkg::color_t          b_in,
	input  astro_pkg::hcount_t         hcount,
	input  astro_pkg::vcount_t         vcount,
	output astro_pkg::color_t          r_out,
	output astro_pkg::color_t          g_out,
	output astro_pkg::color_t          b_out,
	// Audio
	input  astro_pkg::chip_audio_t     chip_l,
	input  astro_pkg::chip_audio_t     chip_r,
	input  astro_pkg::sample_t         samp_l,
	input  astro_pkg::sample_t         samp_r,
	output astro_pkg::sample_t         audio_l,
	output astro_pkg::sample_t         audio_r
);

	import astro_pkg::*;

	// Decoded game flags
	logic  is_ebase, is_spacezap, is_gorf, is_wow, is_robby;
	byte_t dip0, dip2, dip3;

	// Mono switch for Space Zap lives in DIP bank 0
	logic mono_mode;
	assign mono_mode = dip0[1];

	// ======================================================================
	// Blocks
	// ======================================================================

	game_config u_config (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.is_ebase    (is_ebase),
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_wow      (is_wow),
		.is_robby    (is_robby),
		.gorf_prog1  (gorf_prog1),
		.dip0        (dip0),
		.dip2        (dip2),
		.dip3        (dip3)
	);

	switch_matrix u_matrix (
		.col_select  (col_select),
		.p1          (p1),
		.p2          (p2),
		.speech_busy (speech_busy),
		.is_ebase    (is_ebase),
		.is_spacezap (is_spacezap),
		.is_gorf     (is_gorf),
		.is_wow      (is_wow),
		.is_robby    (is_robby),
		.dip0        (dip0),
		.dip2        (dip2),
		.dip3        (dip3),
		.row_data    (row_data)
	);

	video_post u_video (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.r_in        (r_in),
		.g_in        (g_in),
		.b_in        (b_in),
		.hcount      (hcount),
		.vcount      (vcount),
		.is_spacezap (is_spacezap),
		.mono_mode   (mono_mode),
		.r_out       (r_out),
		.g_out       (g_out),
		.b_out       (b_out)
	);

	audio_mix u_audio (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.chip_l   (chip_l),
		.chip_r   (chip_r),
		.samp_l   (samp_l),
		.samp_r   (samp_r),
		.is_gorf  (is_gorf),
		.is_wow   (is_wow),
		.is_robby (is_robby),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

endmodule

//--- verification/astro_io_tb.sv
`timescale 1ns/1ps

module astro_io_tb;

	import astro_pkg::*;

	localparam int RESET_CYCLES  = 10;
	// Flags register one edge after the game id
	localparam int SETTLE_CYCLES = 2;
	// Bound on records read, comment lines included
	localparam int MAX_RECORDS   = 400;

	logic            clk_sys;
	logic            reset;
	logic            dl_wr;
	dl_index_t       dl_index;
	dl_addr_t        dl_addr;
	byte_t           dl_data;
	byte_t           col_select;
	player_buttons_t p1;
	player_buttons_t p2;
	logic            speech_busy;
	byte_t           row_data;
	logic            gorf_prog1;
	color_t          r_in, g_in, b_in;
	hcount_t         hcount;
	vcount_t         vcount;
	color_t          r_out, g_out, b_out;
	chip_audio_t     chip_l, chip_r;
	sample_t         samp_l, samp_r;
	sample_t         audio_l, audio_r;

	// Number of compares done so far
	int checks_done;

	astro_io_top dut (.*);

	// 10 ns system clock
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Checking
	// ======================================================================

	task automatic abort_run(input string what);
		$display("Something failed");
		$display("%s", what);
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, expected));
		end
		checks_done++;
	endtask

	// Counted wait, never runs past its count
	task automatic wait_cycles(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk_sys);
		end
	endtask

	// ======================================================================
	// Record operations
	// ======================================================================

	// One-cycle strobe on the download bus, then let the registers settle
	task automatic download(input logic [31:0] index, input logic [31:0] addr,
		input logic [31:0] data);
		@(posedge clk_sys);
		dl_wr    <= 1'b1;
		dl_index <= index[7:0];
		dl_addr  <= addr[24:0];
		dl_data  <= data[7:0];
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		wait_cycles(SETTLE_CYCLES);
	endtask

	task automatic select_game(input logic [31:0] id, input logic [31:0] prog1);
		download(IDX_GAME, 0, id);
		@(negedge clk_sys);
		check_value("gorf_prog1", gorf_prog1, prog1);
	endtask

	// Matrix is combinational, answer read mid-cycle
	task automatic probe_matrix(input logic [31:0] col, input logic [31:0] btn1,
		input logic [31:0] btn2, input logic [31:0] busy, input logic [31:0] row);
		@(posedge clk_sys);
		col_select  <= col[7:0];
		p1          <= btn1[8:0];
		p2          <= btn2[8:0];
		speech_busy <= busy[0];
		@(negedge clk_sys);
		check_value("row_data", row_data, row);
	endtask

	// Pixel comes out one edge after it is taken in
	task automatic send_pixel(input logic [31:0] r, input logic [31:0] g,
		input logic [31:0] b, input logic [31:0] h, input logic [31:0] v,
		input logic [31:0] rgb);
		@(posedge clk_sys);
		r_in   <= r[3:0];
		g_in   <= g[3:0];
		b_in   <= b[3:0];
		hcount <= h[8:0];
		vcount <= v[10:0];
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("r_out", r_out, rgb[11:8]);
		check_value("g_out", g_out, rgb[7:4]);
		check_value("b_out", b_out, rgb[3:0]);
	endtask

	task automatic send_audio(input logic [31:0] cl, input logic [31:0] cr,
		input logic [31:0] sl, input logic [31:0] sr, input logic [31:0] exp_l,
		input logic [31:0] exp_r);
		@(posedge clk_sys);
		chip_l <= cl[7:0];
		chip_r <= cr[7:0];
		samp_l <= sl[15:0];
		samp_r <= sr[15:0];
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("audio_l", audio_l, exp_l);
		check_value("audio_r", audio_r, exp_r);
	endtask

	// ======================================================================
	// Stimulus file
	// ======================================================================

	task automatic run_records();
		int          fd;
		int          code;
		int          ch;
		int          nargs;
		int          records;
		logic [7:0]  op;
		logic [31:0] arg [6];
		fd = $fopen("verification/astro_io_input.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the stimulus file");
		end
		records = 0;
		code = $fscanf(fd, " %c", op);
		while (code == 1) begin
			records++;
			if (records > MAX_RECORDS) begin
				abort_run("stimulus file holds more records than allowed");
			end
			case (op)
				"#":     nargs = 0;
				"G":     nargs = 2;
				"W":     nargs = 3;
				"M":     nargs = 5;
				"P":     nargs = 6;
				"A":     nargs = 6;
				default: abort_run($sformatf("unknown operation %c in the stimulus file", op));
			endcase
			if (op == "#") begin
				// Comment runs to end of line
				do begin
					ch = $fgetc(fd);
				end while ((ch != "\n") && (ch != -1));
			end
			for (int i = 0; i < nargs; i++) begin
				if ($fscanf(fd, "%h", arg[i]) != 1) begin
					abort_run($sformatf("record %0d in the stimulus file is cut short", records));
				end
			end
			case (op)
				"G": select_game(arg[0], arg[1]);
				"W": download(arg[0], arg[1], arg[2]);
				"M": probe_matrix(arg[0], arg[1], arg[2], arg[3], arg[4]);
				"P": send_pixel(arg[0], arg[1], arg[2], arg[3], arg[4], arg[5]);
				"A": send_audio(arg[0], arg[1], arg[2], arg[3], arg[4], arg[5]);
				default: ;
			endcase
			code = $fscanf(fd, " %c", op);
		end
		$fclose(fd);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		reset       = 1'b1;
		dl_wr       = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		col_select  = '0;
		p1          = '0;
		p2          = '0;
		speech_busy = 1'b0;
		r_in        = '0;
		g_in        = '0;
		b_in        = '0;
		hcount      = '0;
		vcount      = '0;
		chip_l      = '0;
		chip_r      = '0;
		samp_l      = '0;
		samp_r      = '0;
		checks_done = 0;

		wait_cycles(RESET_CYCLES);
		reset <= 1'b0;
		@(negedge clk_sys);

		// Nothing selected yet, so idle row, black screen, silence
		check_value("row_data", row_data, ROW_IDLE);
		check_value("r_out", r_out, 0);
		check_value("g_out", g_out, 0);
		check_value("b_out", b_out, 0);
		check_value("audio_l", audio_l, 0);
		check_value("audio_r", audio_r, 0);

		run_records();

		if (checks_done > 6) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run("the stimulus file gave no checks");
		end
	end

endmodule

//--- verification/astro_io_input.txt
# W index addr data | G game_id gorf_prog1 | M column p1 p2 speech_busy row_data
# P r g b hcount vcount rgb_out | A chip_l chip_r samp_l samp_r audio_l audio_r
M 01 1ff 1ff 1 ff
M 02 000 000 0 ff
M 04 050 010 1 ff
M 08 000 000 0 ff
# Extra Bases, then the other kept games
G 01 0
M 01 050 010 0 ec
M 02 100 000 0 ae
M 04 000 000 0 00
G 03 0
M 01 080 000 0 d7
M 02 000 009 0 f6
M 04 012 000 0 cb
M 10 000 000 0 ff
G 04 0
M 01 100 000 0 39
M 02 000 004 0 3d
M 04 010 000 1 af
G 07 1
M 04 008 000 0 3e
G 05 0
M 01 040 000 0 57
M 02 000 022 0 fb
M 04 010 000 1 cf
G 06 0
M 01 000 000 0 77
M 02 000 010 0 df
M 04 001 000 0 fe
M 08 000 000 0 00
G 02 0
M 01 000 000 0 ff
# DIP banks
G 06 0
W fe 3 5a
M 08 000 000 0 5a
W fe 0b a5
W fe 8 00
M 08 000 000 0 5a
G 01 0
M 08 000 000 0 ff
W fe 2 c3
M 04 000 000 0 c3
# Video edges and Space Zap mono
G 03 0
P 3 5 7 64 64 357
P 1 2 3 46 64 000
P 1 2 3 47 64 123
P 4 4 4 64 15 000
P 4 4 4 64 16 444
P 6 6 6 64 104 000
P 6 6 6 64 103 666
P 9 9 9 64 108 000
P 9 9 9 64 11c 000
P 9 9 9 64 122 999
P 2 f 4 64 64 2f4
W fe 0 02
P 2 f 4 64 64 eee
P 1 3 b 64 64 aaa
P 0 4 b 64 64 888
P 5 6 7 64 64 567
P 2 f 4 10 64 000
G 04 0
P 2 f 4 64 64 2f4
# Audio
A 80 ff 4000 8000 3020 5fff
A 12 00 0104 ffff 04c5 3fff
G 06 0
A 34 56 1234 5678 3434 5656
G 01 0
A ab cd 1234 5678 abab abab
G 02 0
A 11 22 0 0 1111 1111

//--- verilog.f
logic/astro_pkg.sv
logic/game_config.sv
logic/switch_matrix.sv
logic/video_post.sv
logic/audio_mix.sv
logic/astro_io_top.sv
verification/astro_io_tb.sv

//--- Bender.yml
package:
  name: astro_io

sources:
  - logic/astro_pkg.sv
  - logic/game_config.sv
  - logic/switch_matrix.sv
  - logic/video_post.sv
  - logic/audio_mix.sv
  - logic/astro_io_top.sv
  - target: test
    files:
      - verification/astro_io_tb.sv
